// File: rtl/qspi_pkg.sv
`default_nettype none

package qspi_pkg;

	////////////////////////////////////////////////////////////
	// Bus and field widths

	// APB address and data widths
	localparam int ADDR_W = 9;
	localparam int DATA_W = 32;

	// SCK divider width
	localparam int CLKDIV_W = 16;

	// Receive buffer geometry, 64 words of 32 bits
	localparam int BUF_DEPTH = 64;
	localparam int BUF_PTR_W = 6;

	// Burst byte counter, wide enough to hold 256
	localparam int BURST_CNT_W = 9;

	////////////////////////////////////////////////////////////
	// Register map

	// Offsets sit on 0x20 boundaries
	localparam logic [ADDR_W-1:0] REG_CLK_DIV      = 9'h000;
	localparam logic [ADDR_W-1:0] REG_DATA         = 9'h020;
	localparam logic [ADDR_W-1:0] REG_CS_N         = 9'h040;
	localparam logic [ADDR_W-1:0] REG_STATUS       = 9'h060;
	localparam logic [ADDR_W-1:0] REG_STATUS_2     = 9'h080;
	localparam logic [ADDR_W-1:0] REG_BURST_RDLEN  = 9'h0a0;
	localparam logic [ADDR_W-1:0] REG_QUAD_CAP     = 9'h0c0;
	localparam logic [ADDR_W-1:0] REG_QBURST_RDLEN = 9'h0e0;
	// Receive buffer window, runs to the top of the address space
	localparam logic [ADDR_W-1:0] REG_BURST_RXBUF  = 9'h100;

	// Longest burst in bytes, longer requests are clamped
	localparam logic [BURST_CNT_W-1:0] MAX_BURST = 9'd256;

	// Divide ratio seen after reset
	localparam logic [CLKDIV_W-1:0] CLKDIV_RESET = 16'd100;

	// Buffer word, filled byte by byte and read as one word
	// Byte 0 lands in bits 7:0
	typedef union packed {
		logic [DATA_W-1:0]  word;
		logic [3:0][7:0]    bytes;
	} buf_word_t;

endpackage

`default_nettype wire

// File: rtl/qspi_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module qspi_shifter (
	input  wire                          apb,
	input  wire                          rst_n,
	input  wire [qspi_pkg::CLKDIV_W-1:0] clkdiv,
	input  wire                          shift_en,
	input  wire                          quad_en,
	input  wire                          auto_restart,
	input  wire [7:0]                    tx_data,
	output logic                         shift_done,
	output logic [7:0]                   rx_data,
	output logic                         busy,
	output logic                         qspi_sck,
	output logic [3:0]                   qspi_dq_out,
	output logic [3:0]                   qspi_dq_tris,
	input  wire [3:0]                    qspi_dq_in
);

	logic [qspi_pkg::CLKDIV_W-1:0] div_cnt;
	logic [3:0]                    edges_left;
	logic [7:0]                    tx_sr;
	logic                          quad_q;
	logic                          last_q;
	logic                          start;
	logic                          quad_next;
	logic                          run;
	logic                          half_tick;
	logic                          rise;
	logic                          fall;

	// New byte from a command, or chained straight after a done pulse
	assign start     = shift_en || (shift_done && auto_restart);
	assign quad_next = shift_en ? quad_en : quad_q;

	// Clocking phase, excludes the closing low phase and the done cycle
	assign run       = busy && !last_q && !shift_done;
	assign half_tick = (div_cnt == clkdiv);
	assign rise      = run && half_tick && !qspi_sck;
	assign fall      = run && half_tick && qspi_sck;

	// Quad mode reads on all four lanes, single mode drives dq0 only
	assign qspi_dq_out  = quad_q ? tx_sr[7:4] : {3'b000, tx_sr[7]};
	assign qspi_dq_tris = quad_q ? 4'b1111 : 4'b1110;

	////////////////////////////////////////////////////////////
	// SCK and byte sequencing

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			busy       <= 1'b0;
			qspi_sck   <= 1'b0;
			shift_done <= 1'b0;
			last_q     <= 1'b0;
			quad_q     <= 1'b0;
			div_cnt    <= '0;
			edges_left <= '0;
			tx_sr      <= '0;
		end else begin
			shift_done <= 1'b0;
			if (start) begin
				busy       <= 1'b1;
				last_q     <= 1'b0;
				div_cnt    <= '0;
				quad_q     <= quad_next;
				// 8 rising edges per byte in single mode, 2 in quad
				edges_left <= quad_next ? 4'd2 : 4'd8;
				// MSB goes out before the first rising edge
				tx_sr      <= tx_data;
			end else if (shift_done) begin
				busy <= 1'b0;
			end else if (last_q) begin
				// SCK back low, done pulse follows the last rising edge
				last_q     <= 1'b0;
				qspi_sck   <= 1'b0;
				shift_done <= 1'b1;
			end else if (busy) begin
				if (half_tick) begin
					div_cnt  <= '0;
					qspi_sck <= !qspi_sck;
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
				if (rise) begin
					edges_left <= edges_left - 4'd1;
					if (edges_left == 4'd1)
						last_q <= 1'b1;
				end
				// Next bits change on the falling edge
				if (fall)
					tx_sr <= quad_q ? {tx_sr[3:0], 4'b0000} : {tx_sr[6:0], 1'b0};
			end
		end
	end

	// Sample on rising SCK, MSB first
	always_ff @(posedge apb) begin
		if (rise)
			rx_data <= quad_q ? {rx_data[3:0], qspi_dq_in} : {rx_data[6:0], qspi_dq_in[1]};
	end

	// Register stage must wait for the done pulse before the next command
	assert property (@(posedge apb) disable iff (!rst_n) shift_en |-> !busy)
		else $error("shift_en issued while the shifter is busy");

endmodule

`default_nettype wire

// File: rtl/rx_burst_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module rx_burst_buffer (
	input  wire                             apb,
	input  wire                             rst_n,
	input  wire                             burst_start,
	input  wire                             burst_active,
	input  wire                             shift_done,
	input  wire [7:0]                       rx_data,
	input  wire [qspi_pkg::BUF_PTR_W-1:0]   rptr,
	output logic [qspi_pkg::DATA_W-1:0]     rdata,
	output logic [qspi_pkg::BUF_PTR_W:0]    wptr,
	output logic                            word_ready
);

	// Word being packed and the buffer RAM
	qspi_pkg::buf_word_t         wword;
	logic [qspi_pkg::DATA_W-1:0] ram [qspi_pkg::BUF_DEPTH];

	// Byte lane for the next received byte
	logic [1:0]                  wvalid;
	logic                        wr_q;
	logic                        byte_in;
	logic [qspi_pkg::BUF_PTR_W:0] rptr_ext;
	logic                        fwd_hit;

	assign byte_in  = shift_done && burst_active;
	assign rptr_ext = {1'b0, rptr};

	////////////////////////////////////////////////////////////
	// Read port

	// Word is being written this cycle at the read address
	assign fwd_hit    = wr_q && (wptr == rptr_ext);
	assign word_ready = (rptr_ext < wptr) || fwd_hit;
	assign rdata      = fwd_hit ? wword.word : ram[rptr];

	////////////////////////////////////////////////////////////
	// Write side

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			wptr   <= '0;
			wvalid <= '0;
			wr_q   <= 1'b0;
		end else begin
			wr_q <= 1'b0;
			if (burst_start) begin
				// New burst fills from word 0
				wptr   <= '0;
				wvalid <= '0;
			end else begin
				if (wr_q)
					wptr <= wptr + 1'b1;
				if (byte_in) begin
					wvalid <= wvalid + 2'd1;
					// Fourth byte completes the word, write next cycle
					if (wvalid == 2'd3)
						wr_q <= 1'b1;
				end
			end
		end
	end

	// Little-endian packing and RAM write
	always_ff @(posedge apb) begin
		if (byte_in)
			wword.bytes[wvalid] <= rx_data;
		if (wr_q)
			ram[wptr[qspi_pkg::BUF_PTR_W-1:0]] <= wword.word;
	end

	// Clamped burst length keeps the buffer from overflowing
	assert property (@(posedge apb) disable iff (!rst_n) wptr <= qspi_pkg::BUF_DEPTH)
		else $error("receive buffer write pointer past the end");

endmodule

`default_nettype wire

// File: rtl/apb_qspi_regs.sv
`timescale 1ns/1ns
`default_nettype none

module apb_qspi_regs (
	input  wire                             apb,
	input  wire                             rst_n,
	input  wire [qspi_pkg::ADDR_W-1:0]      paddr,
	input  wire                             psel,
	input  wire                             penable,
	input  wire                             pwrite,
	input  wire [qspi_pkg::DATA_W-1:0]      pwdata,
	output logic [qspi_pkg::DATA_W-1:0]     prdata,
	output logic                            pready,
	output logic                            pslverr,
	output logic                            qspi_cs_n,
	input  wire                             shift_done,
	input  wire [7:0]                       rx_data,
	input  wire                             busy,
	input  wire [qspi_pkg::DATA_W-1:0]      rdata,
	input  wire                             word_ready,
	output logic                            shift_en,
	output logic                            quad_en,
	output logic [7:0]                      tx_data,
	output logic [qspi_pkg::CLKDIV_W-1:0]   clkdiv,
	output logic                            auto_restart,
	output logic                            burst_start,
	output logic                            burst_active,
	output logic [qspi_pkg::BUF_PTR_W-1:0]  rptr
);

	logic                               access;
	logic                               wr;
	logic                               rxbuf_sel;
	logic                               reg_mapped;
	logic                               stall;
	logic                               data_wr;
	logic                               burst_wr;
	logic [qspi_pkg::BURST_CNT_W-1:0]   burst_len;
	logic [qspi_pkg::BURST_CNT_W-1:0]   burst_count;
	logic [qspi_pkg::CLKDIV_W-1:0]      clkdiv_rd;
	logic [7:0]                         last_rx;

	////////////////////////////////////////////////////////////
	// APB handshake and decode

	assign access    = psel && penable;
	// Word aligned addresses from 0x100 up hit the receive buffer
	assign rxbuf_sel = (paddr >= qspi_pkg::REG_BURST_RXBUF) && (paddr[1:0] == 2'b00);
	assign rptr      = paddr[qspi_pkg::BUF_PTR_W+1:2];

	// Only a buffer read ahead of the burst waits
	assign stall   = access && !pwrite && rxbuf_sel && burst_active && !word_ready;
	assign pready  = access && !stall;
	assign pslverr = pready && !reg_mapped;
	assign wr      = pready && pwrite;

	always_comb begin
		case (paddr)
			qspi_pkg::REG_CLK_DIV, qspi_pkg::REG_DATA, qspi_pkg::REG_CS_N,
			qspi_pkg::REG_STATUS, qspi_pkg::REG_STATUS_2, qspi_pkg::REG_BURST_RDLEN,
			qspi_pkg::REG_QUAD_CAP, qspi_pkg::REG_QBURST_RDLEN: reg_mapped = 1'b1;
			default: reg_mapped = rxbuf_sel;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Shift commands

	// Commands only go out to an idle shifter, otherwise dropped
	assign data_wr  = wr && (paddr == qspi_pkg::REG_DATA) && !busy;
	assign burst_wr = wr && !busy && !burst_active && (pwdata != '0) &&
		((paddr == qspi_pkg::REG_BURST_RDLEN) || (paddr == qspi_pkg::REG_QBURST_RDLEN));

	// Bursts clock out 0x00 while reading
	assign shift_en     = data_wr || burst_wr;
	assign quad_en      = burst_wr && (paddr == qspi_pkg::REG_QBURST_RDLEN);
	assign tx_data      = data_wr ? pwdata[7:0] : 8'h00;
	assign burst_start  = burst_wr;
	assign auto_restart = burst_active && (burst_count > 9'd1);

	// Clamp to 256 bytes
	assign burst_len = (pwdata > qspi_pkg::MAX_BURST) ? qspi_pkg::MAX_BURST :
		pwdata[qspi_pkg::BURST_CNT_W-1:0];

	////////////////////////////////////////////////////////////
	// Read data

	assign clkdiv_rd = clkdiv + 1'b1;

	always_comb begin
		prdata = '0;
		if (rxbuf_sel) begin
			prdata = rdata;
		end else begin
			case (paddr)
				qspi_pkg::REG_CLK_DIV: prdata[qspi_pkg::CLKDIV_W-1:0] = clkdiv_rd;
				qspi_pkg::REG_DATA:    prdata[7:0] = last_rx;
				qspi_pkg::REG_CS_N:    prdata[0] = qspi_cs_n;
				qspi_pkg::REG_STATUS, qspi_pkg::REG_STATUS_2:
					prdata[0] = busy || burst_active;
				qspi_pkg::REG_QUAD_CAP: prdata[0] = 1'b1;
				// Length registers read back the bytes still to come
				qspi_pkg::REG_BURST_RDLEN, qspi_pkg::REG_QBURST_RDLEN:
					prdata[qspi_pkg::BURST_CNT_W-1:0] = burst_count;
				default: prdata = '0;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Control registers and burst counter

	always_ff @(posedge apb) begin
		if (!rst_n) begin
			qspi_cs_n    <= 1'b1;
			clkdiv       <= qspi_pkg::CLKDIV_RESET - 1'b1;
			burst_active <= 1'b0;
			burst_count  <= '0;
		end else begin
			if (wr && (paddr == qspi_pkg::REG_CS_N))
				qspi_cs_n <= pwdata[0];
			// Divider holds the ratio minus one
			if (wr && (paddr == qspi_pkg::REG_CLK_DIV))
				clkdiv <= pwdata[qspi_pkg::CLKDIV_W-1:0] - 1'b1;
			if (burst_wr) begin
				burst_count  <= burst_len;
				burst_active <= 1'b1;
			end else if (shift_done && burst_active) begin
				burst_count <= burst_count - 1'b1;
				// Last byte ends the burst
				if (burst_count <= 9'd1)
					burst_active <= 1'b0;
			end
		end
	end

	// Most recent byte for REG_DATA reads
	always_ff @(posedge apb) begin
		if (shift_done)
			last_rx <= rx_data;
	end

endmodule

`default_nettype wire

// File: rtl/apb_qspi_host.sv
`timescale 1ns/1ns
`default_nettype none

module apb_qspi_host (
	input  wire                           apb,
	input  wire                           rst_n,
	input  wire [qspi_pkg::ADDR_W-1:0]    paddr,
	input  wire                           psel,
	input  wire                           penable,
	input  wire                           pwrite,
	input  wire [qspi_pkg::DATA_W-1:0]    pwdata,
	output wire [qspi_pkg::DATA_W-1:0]    prdata,
	output wire                           pready,
	output wire                           pslverr,
	output wire                           qspi_sck,
	output wire [3:0]                     qspi_dq_out,
	output wire [3:0]                     qspi_dq_tris,
	output wire                           qspi_cs_n,
	input  wire [3:0]                     qspi_dq_in
);

	// Register stage to shifter
	wire                            shift_en;
	wire                            quad_en;
	wire [7:0]                      tx_data;
	wire [qspi_pkg::CLKDIV_W-1:0]   clkdiv;
	wire                            auto_restart;
	wire                            shift_done;
	wire [7:0]                      rx_data;
	wire                            busy;

	// Register stage to receive buffer
	wire                            burst_start;
	wire                            burst_active;
	wire [qspi_pkg::BUF_PTR_W-1:0]  rptr;
	wire [qspi_pkg::DATA_W-1:0]     rdata;
	wire                            word_ready;

	////////////////////////////////////////////////////////////
	// Pipeline stages

	apb_qspi_regs i_apb_qspi_regs (
		.apb(apb), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .qspi_cs_n(qspi_cs_n), .shift_done(shift_done),
		.rx_data(rx_data), .busy(busy), .rdata(rdata), .word_ready(word_ready),
		.shift_en(shift_en), .quad_en(quad_en), .tx_data(tx_data), .clkdiv(clkdiv),
		.auto_restart(auto_restart), .burst_start(burst_start),
		.burst_active(burst_active), .rptr(rptr)
	);

	qspi_shifter i_qspi_shifter (
		.apb(apb), .rst_n(rst_n), .clkdiv(clkdiv), .shift_en(shift_en),
		.quad_en(quad_en), .auto_restart(auto_restart), .tx_data(tx_data),
		.shift_done(shift_done), .rx_data(rx_data), .busy(busy),
		.qspi_sck(qspi_sck), .qspi_dq_out(qspi_dq_out),
		.qspi_dq_tris(qspi_dq_tris), .qspi_dq_in(qspi_dq_in)
	);

	// Write pointer feeds word_ready only
	rx_burst_buffer i_rx_burst_buffer (
		.apb(apb), .rst_n(rst_n), .burst_start(burst_start),
		.burst_active(burst_active), .shift_done(shift_done), .rx_data(rx_data),
		.rptr(rptr), .rdata(rdata), .wptr(), .word_ready(word_ready)
	);

endmodule

`default_nettype wire

// File: test/qspi_flash_responder.sv
`timescale 1ns/1ns
`default_nettype none

module qspi_flash_responder (
	input  wire        qspi_sck,
	input  wire        qspi_cs_n,
	input  wire [3:0]  qspi_dq_out,
	input  wire [3:0]  qspi_dq_tris,
	input  wire [7:0]  seed,
	output logic [3:0] qspi_dq_in,
	output logic [7:0] last_byte
);

	// Answer shift register and the byte that follows it
	logic [7:0] out_sr = 8'h00;
	logic [7:0] next_byte = 8'h00;
	logic [7:0] cap_sr = 8'h00;
	logic [2:0] rises = 3'd0;
	logic       byte_end = 1'b0;
	logic       quad;

	// All four pins tri-stated by the host means quad read
	assign quad = (qspi_dq_tris == 4'b1111);
	// Single mode answers on dq1 only
	assign qspi_dq_in = quad ? out_sr[7:4] : {2'b00, out_sr[7], 1'b0};

	// Host bits on rising SCK, MSB first
	always @(posedge qspi_sck or posedge qspi_cs_n) begin
		if (qspi_cs_n) begin
			rises    <= 3'd0;
			byte_end <= 1'b0;
		end else begin
			cap_sr <= {cap_sr[6:0], qspi_dq_out[0]};
			if (rises == (quad ? 3'd1 : 3'd7)) begin
				rises    <= 3'd0;
				byte_end <= 1'b1;
				if (!quad)
					last_byte <= {cap_sr[6:0], qspi_dq_out[0]};
			end else begin
				rises    <= rises + 3'd1;
				byte_end <= 1'b0;
			end
		end
	end

	// Answer changes on falling SCK, sequence restarts on deselect
	always @(negedge qspi_sck or posedge qspi_cs_n) begin
		if (qspi_cs_n) begin
			out_sr    <= seed;
			next_byte <= seed + 8'd1;
		end else if (byte_end) begin
			out_sr    <= next_byte;
			next_byte <= next_byte + 8'd1;
		end else if (quad) begin
			out_sr <= {out_sr[3:0], 4'h0};
		end else begin
			out_sr <= {out_sr[6:0], 1'b0};
		end
	end

endmodule

`default_nettype wire

// File: test/tb_apb_qspi_host.sv
`timescale 1ns/1ns
`default_nettype none

module tb_apb_qspi_host;

	// Watchdog budget from a 256 byte single-lane burst at divide ratio 8
	localparam int MAX_RATIO = 8;
	localparam int BYTE_CYCLES = 16 * MAX_RATIO + 4;
	localparam int WATCHDOG_CYCLES = 4 * 256 * BYTE_CYCLES;

	logic        apb;
	logic        rst_n;
	logic [8:0]  paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	wire  [31:0] prdata;
	wire         pready;
	wire         pslverr;
	wire         qspi_sck;
	wire         qspi_cs_n;
	wire  [3:0]  qspi_dq_out;
	wire  [3:0]  qspi_dq_tris;
	wire  [3:0]  qspi_dq_in;
	wire  [7:0]  flash_byte;
	logic [7:0]  resp_seed;
	// Model state, next byte the flash answers with
	logic [7:0]  model_seq;
	integer      seed;

	apb_qspi_host i_apb_qspi_host (
		.apb(apb), .rst_n(rst_n), .paddr(paddr), .psel(psel), .penable(penable),
		.pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .qspi_sck(qspi_sck), .qspi_dq_out(qspi_dq_out),
		.qspi_dq_tris(qspi_dq_tris), .qspi_cs_n(qspi_cs_n), .qspi_dq_in(qspi_dq_in)
	);

	qspi_flash_responder i_flash (
		.qspi_sck(qspi_sck), .qspi_cs_n(qspi_cs_n), .qspi_dq_out(qspi_dq_out),
		.qspi_dq_tris(qspi_dq_tris), .seed(resp_seed), .qspi_dq_in(qspi_dq_in),
		.last_byte(flash_byte)
	);

	////////////////////////////////////////////////////////////
	// Clock and watchdog

	initial begin
		apb = 1'b0;
		forever #20 apb = ~apb;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge apb);
		$display("Timeout after %0d clock cycles, the DUT stopped answering", WATCHDOG_CYCLES);
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////////////////////////
	// Helpers

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
			$display("Verification failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// One APB transfer, waits out PREADY stalls and counts them
	task automatic transfer(input logic write, input logic [8:0] addr, input logic [31:0] wdata,
			input logic exp_err, output logic [31:0] rdata, output int waits);
		waits = 0;
		@(posedge apb);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= write;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge apb);
		penable <= 1'b1;
		@(negedge apb);
		while (!pready) begin
			waits++;
			@(negedge apb);
		end
		rdata = prdata;
		check_value($sformatf("pslverr at 0x%03h", addr), {31'd0, pslverr}, {31'd0, exp_err});
		@(posedge apb);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic write_reg(input logic [8:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		int          waits;
		transfer(1'b1, addr, data, 1'b0, rd, waits);
	endtask

	task automatic expect_reg(input logic [8:0] addr, input logic [31:0] exp, input string what);
		logic [31:0] rd;
		int          waits;
		transfer(1'b0, addr, 32'd0, 1'b0, rd, waits);
		check_value(what, rd, exp);
	endtask

	// Poll a status register until busy clears
	task automatic wait_idle(input logic [8:0] addr);
		logic [31:0] rd;
		int          waits;
		rd = 32'd1;
		while (rd[0])
			transfer(1'b0, addr, 32'd0, 1'b0, rd, waits);
	endtask

	// Four sequence bytes little-endian
	function automatic logic [31:0] pack_word(input logic [7:0] first);
		return {first + 8'd3, first + 8'd2, first + 8'd1, first};
	endfunction

	// Registers every 0x20 below 0x100, aligned buffer words above
	function automatic logic is_mapped(input logic [8:0] addr);
		if (addr[8])
			return addr[1:0] == 2'b00;
		return addr[4:0] == 5'd0;
	endfunction

	function automatic logic [8:0] word_addr(input int index);
		return qspi_pkg::REG_BURST_RXBUF + {index[6:0], 2'b00};
	endfunction

	////////////////////////////////////////////////////////////
	// Test sequence

	initial begin : main
		logic [31:0] rnd;
		logic [31:0] rd;
		logic [31:0] ratio;
		logic [8:0]  addr;
		int          waits;
		int          len;
		seed = 42156;
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		rnd = $random(seed);
		resp_seed = rnd[7:0];
		model_seq = 8'h00;
		repeat (8) @(posedge apb);
		rst_n <= 1'b1;

		// Divider, capability and chip select readback
		rnd = $random(seed);
		ratio = 32'd2 + {29'd0, rnd[2:0] % 3'd7};
		write_reg(qspi_pkg::REG_CLK_DIV, ratio);
		expect_reg(qspi_pkg::REG_CLK_DIV, ratio, "clock divider readback");
		expect_reg(qspi_pkg::REG_QUAD_CAP, 32'd1, "quad capability");
		write_reg(qspi_pkg::REG_CS_N, 32'd0);
		expect_reg(qspi_pkg::REG_CS_N, 32'd0, "chip select low");
		// Deselect restarts the flash answer sequence
		write_reg(qspi_pkg::REG_CS_N, 32'd1);
		expect_reg(qspi_pkg::REG_CS_N, 32'd1, "chip select high");
		model_seq = resp_seed;
		write_reg(qspi_pkg::REG_CS_N, 32'd0);

		// Error response on unmapped offsets only
		for (int i = 0; i < 20; i++) begin
			rnd = $random(seed);
			addr = (i == 0) ? 9'h004 : rnd[8:0];
			if (is_mapped(addr)) begin
				transfer(1'b0, addr, 32'd0, 1'b0, rd, waits);
			end else begin
				transfer(1'b1, addr, rnd, 1'b1, rd, waits);
				transfer(1'b0, addr, 32'd0, 1'b1, rd, waits);
			end
		end

		// Single byte exchange
		rnd = $random(seed);
		write_reg(qspi_pkg::REG_DATA, {24'd0, rnd[7:0]});
		wait_idle(qspi_pkg::REG_STATUS);
		check_value("byte seen by flash", {24'd0, flash_byte}, {24'd0, rnd[7:0]});
		expect_reg(qspi_pkg::REG_DATA, {24'd0, model_seq}, "received byte");
		model_seq = model_seq + 8'd1;

		// Single-lane burst, read after it ends
		rnd = $random(seed);
		len = 4 * (int'(rnd[3:0]) + 1);
		write_reg(qspi_pkg::REG_BURST_RDLEN, len);
		wait_idle(qspi_pkg::REG_STATUS);
		for (int i = 0; i < len / 4; i++)
			expect_reg(word_addr(i), pack_word(model_seq + 8'(4 * i)),
				$sformatf("single burst word %0d", i));
		model_seq = model_seq + 8'(len);

		// Quad burst read while it fills
		rnd = $random(seed);
		len = 4 * (int'(rnd[3:0]) + 1);
		write_reg(qspi_pkg::REG_QBURST_RDLEN, len);
		for (int i = 0; i < len / 4; i++) begin
			transfer(1'b0, word_addr(i), 32'd0, 1'b0, rd, waits);
			if (i == 0)
				check_value("first buffer read stalled", {31'd0, waits > 0}, 32'd1);
			check_value($sformatf("quad burst word %0d", i), rd, pack_word(model_seq + 8'(4 * i)));
		end
		wait_idle(qspi_pkg::REG_STATUS);
		model_seq = model_seq + 8'(len);

		// Overlong quad burst at the fastest divider is cut to 256 bytes
		write_reg(qspi_pkg::REG_CLK_DIV, 32'd1);
		expect_reg(qspi_pkg::REG_CLK_DIV, 32'd1, "fast divider readback");
		rnd = $random(seed);
		write_reg(qspi_pkg::REG_QBURST_RDLEN, 32'd257 + {22'd0, rnd[9:0]});
		wait_idle(qspi_pkg::REG_STATUS_2);
		expect_reg(word_addr(63), pack_word(model_seq + 8'd252), "clamped burst last word");
		expect_reg(qspi_pkg::REG_DATA, {24'd0, model_seq + 8'd255}, "clamped burst last byte");
		// 256 bytes bring the sequence back around
		write_reg(qspi_pkg::REG_DATA, 32'h000000a5);
		wait_idle(qspi_pkg::REG_STATUS);
		expect_reg(qspi_pkg::REG_DATA, {24'd0, model_seq}, "byte after clamped burst");

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// File: apb_qspi_host.f
rtl/qspi_pkg.sv
rtl/qspi_shifter.sv
rtl/rx_burst_buffer.sv
rtl/apb_qspi_regs.sv
rtl/apb_qspi_host.sv
test/qspi_flash_responder.sv
test/tb_apb_qspi_host.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_apb_qspi_host -f apb_qspi_host.f
./obj_dir/Vtb_apb_qspi_host
